// File: Bender.yml
package:
  name: ks_out_process

sources:
  - ks_out_pkg.sv
  - ks_sync_fifo.sv
  - ks_col_tracker.sv
  - ks_lane_proc.sv
  - ks_lane_merge.sv
  - ks_out_process.sv
  - target: test
    include_dirs:
      - .
    files:
      - ks_out_process_asserts.sv
      - tb_ks_out_process.sv

// File: ks_col_tracker.sv
/*
 * per-lane LWE column tracker
 * counts the columns handled by one lane and classifies
 * the current one as mask, last mask, body or dump
 */
`timescale 1ns/10ps

module ks_col_tracker #(
  parameter int LBX      = 2,
  parameter int LWE_K    = 4,
  parameter int LANE_IDX = 0
) (
  input  logic                  clk,
  input  logic                  s_rst_n,
  input  logic                  restart_i,
  input  logic                  avail_i,
  input  logic                  last_pbs_i,
  output ks_out_pkg::col_kind_e kind_o
);

  import ks_out_pkg::*;

  // columns seen by one lane per key-switch loop
  localparam int KS_COL_NB = (LWE_K + LBX) / LBX;
  localparam int COL_W     = (KS_COL_NB > 1) ? $clog2(KS_COL_NB) : 1;
  localparam int IDX_W     = $clog2(LBX * KS_COL_NB + 1);

  logic [COL_W-1:0] col;
  logic [IDX_W-1:0] idx;
  logic             col_end;
  logic             last_col;

  assign col_end  = avail_i & last_pbs_i;
  assign last_col = (col == COL_W'(KS_COL_NB - 1));

  // ------------------------------
  // column counters
  // ------------------------------
  always_ff @(posedge clk) begin
    if (!s_rst_n || restart_i) begin
      col <= '0;
      idx <= IDX_W'(LANE_IDX);
    end else if (col_end) begin
      if (last_col) begin
        col <= '0;
        idx <= IDX_W'(LANE_IDX);
      end else begin
        col <= col + 1'b1;
        idx <= idx + IDX_W'(LBX);
      end
    end
  end

  // lwe column index to kind
  always_comb begin
    if (idx < IDX_W'(LWE_K - 1)) begin
      kind_o = COL_MASK;
    end else if (idx == IDX_W'(LWE_K - 1)) begin
      kind_o = COL_LAST_MASK;
    end else if (idx == IDX_W'(LWE_K)) begin
      kind_o = COL_BODY;
    end else begin
      kind_o = COL_DUMP;
    end
  end

endmodule

// File: ks_lane_merge.sv
/*
 * lane merge of the key-switch output stage
 * reads the lane FIFOs in LWE column order into the output FIFO
 * flags the end of the loop and merges the body write-back
 */
`timescale 1ns/10ps

module ks_lane_merge #(
  parameter int OP_W         = 32,
  parameter int LWE_COEF_W   = 10,
  parameter int CORR_W       = 16,
  parameter int LBX          = 2,
  parameter int BATCH_PBS_NB = 3
) (
  input  logic                           clk,
  input  logic                           s_rst_n,
  input  logic                           restart_i,
  input  logic [LBX-1:0][LWE_COEF_W-1:0] lane_coef_i,
  input  logic [LBX-1:0][CORR_W-1:0]     lane_corr_i,
  input  logic [LBX-1:0]                 lane_last_pbs_i,
  input  logic [LBX-1:0]                 lane_last_mask_i,
  input  logic [LBX-1:0]                 lane_vld_i,
  output logic [LBX-1:0]                 lane_rdy_o,
  input  logic [LBX-1:0]                 lane_body_wr_i,
  input  logic [LBX-1:0][OP_W-1:0]       lane_body_data_i,
  output logic [LWE_COEF_W-1:0]          lwe_coef_o,
  output logic [CORR_W-1:0]              lwe_corr_o,
  output logic                           lwe_vld_o,
  input  logic                           lwe_rdy_i,
  output logic                           loop_done_o,
  output logic                           body_wr_o,
  output logic [OP_W-1:0]                body_wr_data_o
);

  localparam int LBX_W = (LBX > 1) ? $clog2(LBX) : 1;

  typedef struct packed {
    logic                  loop_done;
    logic [CORR_W-1:0]     corr;
    logic [LWE_COEF_W-1:0] coef;
  } out_data_t;

  logic [LBX_W-1:0] lane_ptr;
  logic             last_lane;
  logic             sel_vld;
  logic             sel_last_pbs;
  logic             sel_last_mask;
  logic             ofifo_in_rdy;
  logic             ofifo_wr;
  out_data_t        ofifo_in_data;
  out_data_t        ofifo_out_data;
  logic [OP_W-1:0]  body_data_d;

  // ------------------------------
  // lane selection
  // ------------------------------
  assign sel_vld       = lane_vld_i[lane_ptr];
  assign sel_last_pbs  = lane_last_pbs_i[lane_ptr];
  assign sel_last_mask = lane_last_mask_i[lane_ptr];
  assign last_lane     = (lane_ptr == LBX_W'(LBX - 1));
  assign ofifo_wr      = sel_vld & ofifo_in_rdy;

  always_comb begin
    for (int i = 0; i < LBX; i++) begin
      lane_rdy_o[i] = (lane_ptr == LBX_W'(i)) & ofifo_in_rdy;
    end
  end

  // stay on a lane until its column ends
  always_ff @(posedge clk) begin
    if (!s_rst_n || restart_i) begin
      lane_ptr <= '0;
    end else if (ofifo_wr && sel_last_pbs) begin
      lane_ptr <= (last_lane || sel_last_mask) ? '0 : lane_ptr + 1'b1;
    end
  end

  assign ofifo_in_data.coef      = lane_coef_i[lane_ptr];
  assign ofifo_in_data.corr      = lane_corr_i[lane_ptr];
  assign ofifo_in_data.loop_done = sel_last_pbs & sel_last_mask;

  ks_sync_fifo #(
    .DEPTH  (LBX * BATCH_PBS_NB * 2),
    .data_t (out_data_t)
  ) u_out_fifo (
    .clk        (clk),
    .s_rst_n    (s_rst_n),
    .flush_i    (restart_i),
    .in_data_i  (ofifo_in_data),
    .in_vld_i   (sel_vld),
    .in_rdy_o   (ofifo_in_rdy),
    .out_data_o (ofifo_out_data),
    .out_vld_o  (lwe_vld_o),
    .out_rdy_i  (lwe_rdy_i)
  );

  assign lwe_coef_o = ofifo_out_data.coef;
  assign lwe_corr_o = ofifo_out_data.corr;

  // ------------------------------
  // loop end and body write-back
  // ------------------------------
  always_comb begin
    body_data_d = '0;
    for (int i = 0; i < LBX; i++) begin
      body_data_d = body_data_d | (lane_body_data_i[i] & {OP_W{lane_body_wr_i[i]}});
    end
  end

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      loop_done_o <= 1'b0;
      body_wr_o   <= 1'b0;
    end else begin
      loop_done_o <= lwe_vld_o & lwe_rdy_i & ofifo_out_data.loop_done;
      body_wr_o   <= |lane_body_wr_i;
    end
  end

  always_ff @(posedge clk) begin
    body_wr_data_o <= body_data_d;
  end

endmodule

// File: ks_lane_proc.sv
/*
 * one key-switch output lane
 * s0 input register and body subtraction
 * s1 mod switch to 2N with rounding and mean-compensation error
 * s2 body write strobe and lane FIFO write
 */
`timescale 1ns/10ps

module ks_lane_proc #(
  parameter int OP_W          = 32,
  parameter int LWE_COEF_W    = 10,
  parameter int CORR_W        = 16,
  parameter int LBX           = 2,
  parameter int LWE_K         = 4,
  parameter int BATCH_PBS_NB  = 3,
  parameter int USE_MEAN_COMP = 1,
  parameter int LANE_IDX      = 0
) (
  input  logic                  clk,
  input  logic                  s_rst_n,
  input  logic                  restart_i,
  input  logic [OP_W-1:0]       mult_data_i,
  input  logic                  mult_avail_i,
  input  logic                  mult_last_pbs_i,
  input  logic [OP_W-1:0]       body_i,
  output logic                  body_pop_o,
  output logic                  body_wr_o,
  output logic [OP_W-1:0]       body_wr_data_o,
  output logic [LWE_COEF_W-1:0] lane_coef_o,
  output logic [CORR_W-1:0]     lane_corr_o,
  output logic                  lane_last_pbs_o,
  output logic                  lane_last_mask_o,
  output logic                  lane_vld_o,
  input  logic                  lane_rdy_i
);

  import ks_out_pkg::*;

  localparam int ERR_W = OP_W - LWE_COEF_W;

  typedef struct packed {
    logic [CORR_W-1:0]     corr;
    logic                  last_pbs;
    logic                  last_mask;
    logic [LWE_COEF_W-1:0] coef;
  } lane_data_t;

  logic                  s0_avail;
  logic [OP_W-1:0]       s0_data;
  logic                  s0_last_pbs;
  col_kind_e             s0_kind;
  logic                  s0_is_mask;
  logic [OP_W-1:0]       s0_coef;
  logic                  s1_mask_avail;
  logic                  s1_body_avail;
  logic [OP_W-1:0]       s1_coef;
  logic                  s1_last_pbs;
  logic                  s1_last_mask;
  logic [LWE_COEF_W-1:0] s1_mdsw;
  logic [ERR_W-1:0]      s1_err;
  logic [CORR_W-1:0]     s1_corr;
  logic                  s2_mask_avail;
  logic                  s2_body_avail;
  logic [OP_W-1:0]       s2_coef;
  lane_data_t            s2_data;
  logic                  lfifo_in_rdy;
  lane_data_t            lfifo_out_data;

  // ------------------------------
  // s0
  // ------------------------------
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      s0_avail <= 1'b0;
    end else begin
      s0_avail <= mult_avail_i;
    end
  end

  always_ff @(posedge clk) begin
    s0_data     <= mult_data_i;
    s0_last_pbs <= mult_last_pbs_i;
  end

  ks_col_tracker #(
    .LBX      (LBX),
    .LWE_K    (LWE_K),
    .LANE_IDX (LANE_IDX)
  ) u_col_tracker (
    .clk        (clk),
    .s_rst_n    (s_rst_n),
    .restart_i  (restart_i),
    .avail_i    (s0_avail),
    .last_pbs_i (s0_last_pbs),
    .kind_o     (s0_kind)
  );

  assign s0_is_mask = (s0_kind == COL_MASK) || (s0_kind == COL_LAST_MASK);
  assign body_pop_o = s0_avail && (s0_kind == COL_BODY);
  // (0,..,0,b) minus the accumulated product, modulo 2^OP_W
  assign s0_coef = ((s0_kind == COL_BODY) ? body_i : '0) - s0_data;

  // ------------------------------
  // s1
  // ------------------------------
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      s1_mask_avail <= 1'b0;
      s1_body_avail <= 1'b0;
    end else begin
      s1_mask_avail <= s0_avail & s0_is_mask;
      s1_body_avail <= body_pop_o;
    end
  end

  always_ff @(posedge clk) begin
    s1_coef      <= s0_coef;
    s1_last_pbs  <= s0_last_pbs;
    s1_last_mask <= (s0_kind == COL_LAST_MASK);
  end

  // keep the top bits, round with the first dropped one
  assign s1_mdsw = s1_coef[OP_W-1 -: LWE_COEF_W] + LWE_COEF_W'(s1_coef[ERR_W-1]);
  assign s1_err  = s1_coef[ERR_W-1:0];
  assign s1_corr = (USE_MEAN_COMP != 0) ? CORR_W'($signed(s1_err)) : '0;

  // ------------------------------
  // s2
  // ------------------------------
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      s2_mask_avail <= 1'b0;
      s2_body_avail <= 1'b0;
    end else begin
      s2_mask_avail <= s1_mask_avail;
      s2_body_avail <= s1_body_avail;
    end
  end

  always_ff @(posedge clk) begin
    s2_coef           <= s1_coef;
    s2_data.coef      <= s1_mdsw;
    s2_data.corr      <= s1_corr;
    s2_data.last_pbs  <= s1_last_pbs;
    s2_data.last_mask <= s1_last_mask;
  end

  assign body_wr_o      = s2_body_avail;
  assign body_wr_data_o = s2_coef;

  // sized so that a full column can wait for the merge
  ks_sync_fifo #(
    .DEPTH  (2 * BATCH_PBS_NB),
    .data_t (lane_data_t)
  ) u_lane_fifo (
    .clk        (clk),
    .s_rst_n    (s_rst_n),
    .flush_i    (restart_i),
    .in_data_i  (s2_data),
    .in_vld_i   (s2_mask_avail),
    .in_rdy_o   (lfifo_in_rdy),
    .out_data_o (lfifo_out_data),
    .out_vld_o  (lane_vld_o),
    .out_rdy_i  (lane_rdy_i)
  );

  assign lane_coef_o      = lfifo_out_data.coef;
  assign lane_corr_o      = lfifo_out_data.corr;
  assign lane_last_pbs_o  = lfifo_out_data.last_pbs;
  assign lane_last_mask_o = lfifo_out_data.last_mask;

endmodule

// File: ks_out_pkg.sv
/*
 * default widths and counts of the key-switch output stage
 * column kind enum shared by the column tracker and the lanes
 */
package ks_out_pkg;

  // ------------------------------
  // datapath widths
  // ------------------------------
  // accumulator word
  parameter int DEF_OP_W       = 32;
  // log2 of 2N
  parameter int DEF_LWE_COEF_W = 10;
  // signed rounding error
  parameter int DEF_CORR_W     = 16;

  // ------------------------------
  // counts
  // ------------------------------
  parameter int DEF_LBX          = 2;
  // body sits at column index LWE_K
  parameter int DEF_LWE_K        = 4;
  parameter int DEF_BATCH_PBS_NB = 3;
  parameter int DEF_USE_MEAN_COMP = 1;

  // kind of the column a lane is currently processing
  typedef enum logic [1:0] {
    COL_MASK,
    COL_LAST_MASK,
    COL_BODY,
    COL_DUMP
  } col_kind_e;

endpackage

// File: ks_out_process.f
+incdir+.
ks_out_pkg.sv
ks_sync_fifo.sv
ks_col_tracker.sv
ks_lane_proc.sv
ks_lane_merge.sv
ks_out_process.sv
ks_out_process_asserts.sv
tb_ks_out_process.sv

// File: ks_out_process.sv
/*
 * key-switch output stage top level
 * restart and key read pointer registers, body FIFO,
 * LBX output lanes and the lane merge
 */
`timescale 1ns/10ps

module ks_out_process #(
  parameter int OP_W          = ks_out_pkg::DEF_OP_W,
  parameter int LWE_COEF_W    = ks_out_pkg::DEF_LWE_COEF_W,
  parameter int CORR_W        = ks_out_pkg::DEF_CORR_W,
  parameter int LBX           = ks_out_pkg::DEF_LBX,
  parameter int LWE_K         = ks_out_pkg::DEF_LWE_K,
  parameter int BATCH_PBS_NB  = ks_out_pkg::DEF_BATCH_PBS_NB,
  parameter int USE_MEAN_COMP = ks_out_pkg::DEF_USE_MEAN_COMP
) (
  input  logic                     clk,
  input  logic                     s_rst_n,
  input  logic [LBX-1:0][OP_W-1:0] mult_data_i,
  input  logic [LBX-1:0]           mult_avail_i,
  input  logic [LBX-1:0]           mult_last_pbs_i,
  input  logic [OP_W-1:0]          body_data_i,
  input  logic                     body_vld_i,
  output logic                     body_rdy_o,
  input  logic                     restart_i,
  output logic [LWE_COEF_W-1:0]    lwe_coef_o,
  output logic [CORR_W-1:0]        lwe_corr_o,
  output logic                     lwe_vld_o,
  input  logic                     lwe_rdy_i,
  output logic                     loop_done_o,
  output logic                     ksk_rd_inc_o,
  output logic                     body_wr_o,
  output logic [OP_W-1:0]          body_wr_data_o
);

  logic                           restart_q;
  logic                           ksk_inc_s0;
  logic [OP_W-1:0]                body;
  logic                           body_vld;
  logic [LBX-1:0]                 lane_body_pop;
  logic [LBX-1:0]                 lane_body_wr;
  logic [LBX-1:0][OP_W-1:0]       lane_body_data;
  logic [LBX-1:0][LWE_COEF_W-1:0] lane_coef;
  logic [LBX-1:0][CORR_W-1:0]     lane_corr;
  logic [LBX-1:0]                 lane_last_pbs;
  logic [LBX-1:0]                 lane_last_mask;
  logic [LBX-1:0]                 lane_vld;
  logic [LBX-1:0]                 lane_rdy;

  // ------------------------------
  // restart and key read pointer
  // ------------------------------
  // a column set ends when the last lane closes its column
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      restart_q    <= 1'b0;
      ksk_inc_s0   <= 1'b0;
      ksk_rd_inc_o <= 1'b0;
    end else begin
      restart_q    <= restart_i;
      ksk_inc_s0   <= mult_avail_i[LBX-1] & mult_last_pbs_i[LBX-1];
      ksk_rd_inc_o <= ksk_inc_s0;
    end
  end

  // body values, one per coefficient of the body column
  ks_sync_fifo #(
    .DEPTH  (2),
    .data_t (logic [OP_W-1:0])
  ) u_body_fifo (
    .clk        (clk),
    .s_rst_n    (s_rst_n),
    .flush_i    (restart_q),
    .in_data_i  (body_data_i),
    .in_vld_i   (body_vld_i),
    .in_rdy_o   (body_rdy_o),
    .out_data_o (body),
    .out_vld_o  (body_vld),
    .out_rdy_i  (|lane_body_pop)
  );

  for (genvar g = 0; g < LBX; g++) begin : gen_lane
    ks_lane_proc #(
      .OP_W          (OP_W),
      .LWE_COEF_W    (LWE_COEF_W),
      .CORR_W        (CORR_W),
      .LBX           (LBX),
      .LWE_K         (LWE_K),
      .BATCH_PBS_NB  (BATCH_PBS_NB),
      .USE_MEAN_COMP (USE_MEAN_COMP),
      .LANE_IDX      (g)
    ) u_lane (
      .clk              (clk),
      .s_rst_n          (s_rst_n),
      .restart_i        (restart_q),
      .mult_data_i      (mult_data_i[g]),
      .mult_avail_i     (mult_avail_i[g]),
      .mult_last_pbs_i  (mult_last_pbs_i[g]),
      .body_i           (body),
      .body_pop_o       (lane_body_pop[g]),
      .body_wr_o        (lane_body_wr[g]),
      .body_wr_data_o   (lane_body_data[g]),
      .lane_coef_o      (lane_coef[g]),
      .lane_corr_o      (lane_corr[g]),
      .lane_last_pbs_o  (lane_last_pbs[g]),
      .lane_last_mask_o (lane_last_mask[g]),
      .lane_vld_o       (lane_vld[g]),
      .lane_rdy_i       (lane_rdy[g])
    );
  end

  ks_lane_merge #(
    .OP_W         (OP_W),
    .LWE_COEF_W   (LWE_COEF_W),
    .CORR_W       (CORR_W),
    .LBX          (LBX),
    .BATCH_PBS_NB (BATCH_PBS_NB)
  ) u_merge (
    .clk              (clk),
    .s_rst_n          (s_rst_n),
    .restart_i        (restart_q),
    .lane_coef_i      (lane_coef),
    .lane_corr_i      (lane_corr),
    .lane_last_pbs_i  (lane_last_pbs),
    .lane_last_mask_i (lane_last_mask),
    .lane_vld_i       (lane_vld),
    .lane_rdy_o       (lane_rdy),
    .lane_body_wr_i   (lane_body_wr),
    .lane_body_data_i (lane_body_data),
    .lwe_coef_o       (lwe_coef_o),
    .lwe_corr_o       (lwe_corr_o),
    .lwe_vld_o        (lwe_vld_o),
    .lwe_rdy_i        (lwe_rdy_i),
    .loop_done_o      (loop_done_o),
    .body_wr_o        (body_wr_o),
    .body_wr_data_o   (body_wr_data_o)
  );

endmodule

// File: ks_out_process_asserts.sv
/*
 * concurrent checks of the key-switch output stage
 * lane FIFO overflow, body FIFO pop rules
 * bound into the top level
 */
`timescale 1ns/10ps

module ks_out_process_asserts #(
  parameter int LBX = 2
) (
  input logic           clk,
  input logic           s_rst_n,
  input logic [LBX-1:0] body_pop_i,
  input logic           body_vld_i,
  input logic [LBX-1:0] lfifo_wr_i,
  input logic [LBX-1:0] lfifo_rdy_i
);

  // failed assertions so far
  int fail_cnt = 0;

  // ------------------------------
  // lane FIFOs
  // ------------------------------
  for (genvar g = 0; g < LBX; g++) begin : gen_lane_chk
    a_lfifo_full : assert property (@(posedge clk) disable iff (!s_rst_n)
      lfifo_wr_i[g] |-> lfifo_rdy_i[g])
      else begin
        $error("lane %0d FIFO written while full", g);
        fail_cnt++;
      end
  end

  // ------------------------------
  // body FIFO
  // ------------------------------
  a_body_vld : assert property (@(posedge clk) disable iff (!s_rst_n)
    (|body_pop_i) |-> body_vld_i)
    else begin
      $error("body FIFO popped while empty");
      fail_cnt++;
    end

  a_one_pop : assert property (@(posedge clk) disable iff (!s_rst_n)
    $onehot0(body_pop_i))
    else begin
      $error("more than one lane pops the body FIFO");
      fail_cnt++;
    end

endmodule

// lane FIFO write side wired for the two-lane default
bind ks_out_process ks_out_process_asserts #(.LBX(LBX)) u_asserts (
  .clk         (clk),
  .s_rst_n     (s_rst_n),
  .body_pop_i  (lane_body_pop),
  .body_vld_i  (body_vld),
  .lfifo_wr_i  ({gen_lane[1].u_lane.s2_mask_avail, gen_lane[0].u_lane.s2_mask_avail}),
  .lfifo_rdy_i ({gen_lane[1].u_lane.lfifo_in_rdy, gen_lane[0].u_lane.lfifo_in_rdy})
);

// File: ks_sync_fifo.sv
/*
 * synchronous register-array FIFO
 * payload type given by a type parameter
 * valid/ready on both sides, flush empties it
 */
`timescale 1ns/10ps

module ks_sync_fifo #(
  parameter int  DEPTH  = 2,
  parameter type data_t = logic
) (
  input  logic  clk,
  input  logic  s_rst_n,
  input  logic  flush_i,

  input  data_t in_data_i,
  input  logic  in_vld_i,
  output logic  in_rdy_o,

  output data_t out_data_o,
  output logic  out_vld_o,
  input  logic  out_rdy_i
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  data_t            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             wr_en;
  logic             rd_en;

  // pointers wrap at DEPTH, which need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    ptr_next = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign in_rdy_o   = (count != CNT_W'(DEPTH));
  assign out_vld_o  = (count != '0);
  assign out_data_o = mem[rd_ptr];

  assign wr_en = in_vld_i & in_rdy_o;
  assign rd_en = out_vld_o & out_rdy_i;

  // ------------------------------
  // pointers and occupancy
  // ------------------------------
  always_ff @(posedge clk) begin
    if (!s_rst_n || flush_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (rd_en) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      if (wr_en && !rd_en) begin
        count <= count + 1'b1;
      end else if (rd_en && !wr_en) begin
        count <= count - 1'b1;
      end
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= in_data_i;
    end
  end

endmodule

// File: tb_ks_out_process_check.svh
/*
 * testbench helpers of the key-switch output stage
 * reference mod switch and rounding error, stimulus data,
 * expected queues, bounded end-of-loop wait, reporting
 */
`ifndef TB_KS_OUT_PROCESS_CHECK_SVH
`define TB_KS_OUT_PROCESS_CHECK_SVH

  // round to nearest, add half of the dropped weight and keep the top bits
  function automatic logic [LWE_COEF_W-1:0] round_coef(input logic [OP_W-1:0] v);
    logic [OP_W:0] half;
    logic [OP_W:0] sum;
    half = '0;
    half[ERR_W-1] = 1'b1;
    sum = {1'b0, v} + half;
    return sum[OP_W-1 -: LWE_COEF_W];
  endfunction

  // value minus its nearest multiple of 2^ERR_W
  function automatic logic [CORR_W-1:0] round_err(input logic [OP_W-1:0] v);
    logic [OP_W:0] half;
    logic [OP_W:0] sum;
    logic [OP_W:0] err;
    half = '0;
    half[ERR_W-1] = 1'b1;
    sum = {1'b0, v} + half;
    sum[ERR_W-1:0] = '0;
    err = {1'b0, v} - sum;
    return (USE_MEAN_COMP != 0) ? err[CORR_W-1:0] : '0;
  endfunction

  task automatic check_val(input string name, input logic [63:0] got,
                           input logic [63:0] exp);
    checks++;
    assert (got === exp)
      else begin
        $display("CHECK FAILED t=%0t %s got %h exp %h", $time, name, got, exp);
        errors++;
      end
  endtask

  task automatic fill_data(input bit rnd);
    for (int c = 0; c < COL_NB; c++) begin
      for (int k = 0; k < BPN; k++) begin
        if (rnd) begin
          col_data[c][k] = $random(seed);
        end else begin
          col_data[c][k] = OP_W'((c * BPN + k + 1) * 32'h0123_4567);
        end
      end
    end
  endtask

  // masks negated and mod switched, body minus input
  task automatic build_expected(input logic [OP_W-1:0] body);
    logic [OP_W-1:0] neg;
    for (int c = 0; c < LWE_K; c++) begin
      for (int k = 0; k < BPN; k++) begin
        neg = '0 - col_data[c][k];
        exp_coef.push_back(round_coef(neg));
        exp_corr.push_back(round_err(neg));
      end
    end
    for (int k = 0; k < BPN; k++) begin
      body_q.push_back(body + OP_W'(k));
      exp_body.push_back(body + OP_W'(k) - col_data[LWE_K][k]);
    end
    done_seen = 0;
  endtask

  task automatic wait_loop_end();
    int t;
    t = 0;
    while (!(exp_coef.size() == 0 && exp_body.size() == 0 && exp_ksk_cyc.size() == 0 &&
             done_seen > 0) && t < TIMEOUT) begin
      @(posedge clk);
      t++;
    end
    if (t >= TIMEOUT) begin
      $display("timeout waiting for the end of loop %0d", tests);
      timed_out = 1;
    end
  endtask

  task automatic report_test(input int r);
    $display("test %0d body %h %s stall %0d restart %0d finished, errors %0d",
             r, rows[r].body, rows[r].rnd ? "random" : "fixed", rows[r].stall,
             rows[r].restart, errors);
  endtask

`endif

// File: tb_ks_out_process.sv
/*
 * testbench of the key-switch output stage
 * clock, reset, table of loops, input and body drivers,
 * output monitor with checks
 */
`timescale 1ns/10ps

module tb_ks_out_process;

  import ks_out_pkg::*;

  localparam int OP_W = DEF_OP_W;
  localparam int LWE_COEF_W = DEF_LWE_COEF_W;
  localparam int CORR_W = DEF_CORR_W;
  localparam int LBX = DEF_LBX;
  localparam int LWE_K = DEF_LWE_K;
  localparam int BPN = DEF_BATCH_PBS_NB;
  localparam int USE_MEAN_COMP = DEF_USE_MEAN_COMP;
  localparam int SET_NB = (LWE_K + LBX) / LBX;
  localparam int COL_NB = SET_NB * LBX;
  localparam int ERR_W = OP_W - LWE_COEF_W;
  localparam int ROW_NB = 4;
  localparam int TIMEOUT = 2000;

  typedef struct {
    logic [OP_W-1:0] body;
    bit              rnd;
    int              stall;
    bit              restart;
  } row_t;

  logic clk = 1'b0;
  logic s_rst_n;
  logic [LBX-1:0][OP_W-1:0] mult_data_i;
  logic [LBX-1:0] mult_avail_i;
  logic [LBX-1:0] mult_last_pbs_i;
  logic [OP_W-1:0] body_data_i;
  logic body_vld_i;
  logic body_rdy_o;
  logic restart_i;
  logic [LWE_COEF_W-1:0] lwe_coef_o;
  logic [CORR_W-1:0] lwe_corr_o;
  logic lwe_vld_o;
  logic lwe_rdy_i;
  logic loop_done_o;
  logic ksk_rd_inc_o;
  logic body_wr_o;
  logic [OP_W-1:0] body_wr_data_o;

  row_t rows [ROW_NB];
  logic [OP_W-1:0] col_data [COL_NB][BPN];
  logic [OP_W-1:0] body_q [$];
  logic [LWE_COEF_W-1:0] exp_coef [$];
  logic [CORR_W-1:0] exp_corr [$];
  logic [OP_W-1:0] exp_body [$];
  int exp_body_cyc [$];
  int exp_ksk_cyc [$];
  integer seed = 32'he15d_6785;
  int cycle = 0;
  int done_cycle = -1;
  int done_seen;
  int checks;
  int errors;
  int tests;
  bit ignore;
  bit body_fire;
  bit timed_out;

  `include "tb_ks_out_process_check.svh"

  always #20 clk = ~clk;

  ks_out_process DUT (.*);

  // body FIFO feeder, handshake seen at the falling edge
  always @(negedge clk) body_fire = body_vld_i & body_rdy_o;
  always @(posedge clk) begin
    cycle = cycle + 1;
    #2;
    if (body_fire) void'(body_q.pop_front());
    body_vld_i = (body_q.size() > 0);
    if (body_q.size() > 0) body_data_i = body_q[0];
  end

  // ------------------------------
  // output monitor
  // ------------------------------
  always @(negedge clk) begin
    if (s_rst_n && !ignore) begin
      if (lwe_vld_o && lwe_rdy_i) begin
        if (exp_coef.size() == 0) begin
          $display("unexpected lwe output at t=%0t", $time);
          errors++;
        end else begin
          check_val("lwe_coef_o", lwe_coef_o, exp_coef.pop_front());
          check_val("lwe_corr_o", lwe_corr_o, exp_corr.pop_front());
          if (exp_coef.size() == 0) done_cycle = cycle + 1;
        end
      end
      if (loop_done_o) begin
        done_seen++;
        check_val("loop_done_o cycle", cycle, done_cycle);
      end
      if (body_wr_o) begin
        if (exp_body.size() == 0) begin
          $display("unexpected body write-back at t=%0t", $time);
          errors++;
        end else begin
          check_val("body_wr_data_o", body_wr_data_o, exp_body.pop_front());
          check_val("body_wr_o cycle", cycle, exp_body_cyc.pop_front());
        end
      end
      if (ksk_rd_inc_o) begin
        if (exp_ksk_cyc.size() == 0) begin
          $display("unexpected ksk_rd_inc_o pulse at t=%0t", $time);
          errors++;
        end else begin
          check_val("ksk_rd_inc_o cycle", cycle, exp_ksk_cyc.pop_front());
        end
      end
    end
  end

  // column sets back to back, lane l of set s carries column s*LBX+l
  task automatic drive_sets(input int n);
    int c;
    for (int s = 0; s < n; s++) begin
      for (int k = 0; k < BPN; k++) begin
        @(posedge clk);
        #2;
        for (int l = 0; l < LBX; l++) begin
          c = s * LBX + l;
          if (c == LWE_K && k == 0 && !ignore) begin
            // body FIFO full while the rest of the body waits
            check_val("body_rdy_o", body_rdy_o, 1'b0);
          end
          mult_data_i[l] = col_data[c][k];
          mult_avail_i[l] = 1'b1;
          mult_last_pbs_i[l] = (k == BPN - 1);
          if (c == LWE_K && !ignore) exp_body_cyc.push_back(cycle + 4);
        end
        if (k == BPN - 1 && !ignore) exp_ksk_cyc.push_back(cycle + 2);
      end
    end
    @(posedge clk);
    #2;
    mult_avail_i = '0;
    mult_last_pbs_i = '0;
  endtask

  initial begin
    rows[0] = '{32'h1000_0000, 1'b0, 0, 1'b0};
    rows[1] = '{32'hdead_beef, 1'b1, 0, 1'b0};
    rows[2] = '{32'h8000_0001, 1'b1, 25, 1'b0};
    rows[3] = '{32'h0000_0042, 1'b0, 10, 1'b1};
    {mult_data_i, mult_avail_i, mult_last_pbs_i} = '0;
    {body_data_i, body_vld_i, restart_i, lwe_rdy_i} = '0;
    {done_seen, checks, errors, tests} = '0;
    {ignore, body_fire, timed_out} = '0;
    s_rst_n = 1'b0;
    repeat (8) @(posedge clk);
    #2 s_rst_n = 1'b1;
    for (int r = 0; r < ROW_NB && !timed_out; r++) begin
      @(posedge clk);
      if (rows[r].restart) begin
        // partial loop thrown away by the restart
        ignore = 1;
        fill_data(1'b1);
        #2 lwe_rdy_i = 1'b0;
        drive_sets(1);
        repeat (6) @(posedge clk);
        #2 restart_i = 1'b1;
        @(posedge clk);
        #2 restart_i = 1'b0;
        repeat (3) @(posedge clk);
        ignore = 0;
      end
      fill_data(rows[r].rnd);
      build_expected(rows[r].body);
      fork
        begin
          #2 lwe_rdy_i = (rows[r].stall == 0);
          repeat (rows[r].stall) @(posedge clk);
          #2 lwe_rdy_i = 1'b1;
        end
        drive_sets(SET_NB);
      join
      wait_loop_end();
      repeat (4) @(posedge clk);
      // every body value consumed, FIFO empty again
      #2 check_val("body_rdy_o", body_rdy_o, 1'b1);
      tests++;
      report_test(r);
    end
    $display("tests %0d checks %0d errors %0d assertion failures %0d",
             tests, checks, errors, DUT.u_asserts.fail_cnt);
    if (timed_out || errors != 0 || DUT.u_asserts.fail_cnt != 0) begin
      $display("Test FAILED");
    end else begin
      $display("Test OK");
    end
    $finish;
  end

endmodule
